// File: uart_pkg.sv
`default_nettype none

package uart_pkg;

  // Baud divisor width shared by the generator and the top level
  localparam int BSEL_W = 12;

  // N gives one strobe every N+1 clock cycles
  typedef logic [BSEL_W-1:0] baud_div_t;

  typedef enum logic [1:0] {
    PAR_NONE = 2'b00,
    PAR_EVEN = 2'b01, // Total count of ones is even
    PAR_ODD  = 2'b10  // Total count of ones is odd
  } parity_t;

endpackage

`default_nettype wire

// File: clk_gen_logic.sv
`default_nettype none

module clk_gen_logic (
  input  logic                clk,
  input  logic                nrst,
  input  uart_pkg::baud_div_t bsel,
  input  logic                change_cfg,
  input  logic                rxen,
  input  logic                txen,
  input  logic                clr_tx_cnt,
  output logic                rx_clk_en,
  output logic                tx_clk_en
);

  import uart_pkg::*;

  baud_div_t rx_cnt;
  baud_div_t rx_cnt_next;
  baud_div_t tx_cnt;
  baud_div_t tx_cnt_next;
  logic      rx_cnt_exp;
  logic      tx_cnt_exp;
  logic      tx_clk_en_next;
  logic      bsel_zero;

  assign rx_cnt_exp = (rx_cnt == '0);
  assign tx_cnt_exp = (tx_cnt == '0);
  assign bsel_zero  = (bsel == '0);

  always_comb
  begin
    rx_cnt_next    = rx_cnt;
    tx_cnt_next    = tx_cnt;
    tx_clk_en_next = tx_clk_en;

    if (change_cfg || rx_cnt_exp)
      rx_cnt_next = bsel;
    else if (rxen)
      rx_cnt_next = rx_cnt - BSEL_W'(1);

    // Transmit side also restarts at frame start
    if (change_cfg || tx_cnt_exp || clr_tx_cnt)
      tx_cnt_next = bsel;
    else if (txen)
      tx_cnt_next = tx_cnt - BSEL_W'(1);

    if (!tx_clk_en)
    begin
      if (txen && (tx_cnt_next == '0 || bsel_zero))
        tx_clk_en_next = 1'b1;
    end
    else if (!bsel_zero || !txen)
      tx_clk_en_next = 1'b0; // Held high only for divide by one
  end

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      rx_cnt    <= '0;
      tx_cnt    <= '0;
      rx_clk_en <= 1'b0;
      tx_clk_en <= 1'b0;
    end
    else
    begin
      rx_cnt    <= rx_cnt_next;
      tx_cnt    <= tx_cnt_next;
      rx_clk_en <= rx_cnt_exp && rxen;
      tx_clk_en <= tx_clk_en_next;
    end
  end

  rx_en_gated: assert property (@(posedge clk) disable iff (!nrst)
    !rxen |=> !rx_clk_en);

  tx_single_strobe: assert property (@(posedge clk) disable iff (!nrst)
    (tx_clk_en && !bsel_zero) |=> !tx_clk_en);

endmodule

`default_nettype wire

// File: uart_tx.sv
`default_nettype none

module uart_tx #(
  parameter int DATA_BITS  = 8,
  parameter int OVERSAMPLE = 16
) (
  input  logic                 clk,
  input  logic                 nrst,
  input  logic                 tx_clk_en,
  input  logic                 tx_start,
  input  logic [DATA_BITS-1:0] tx_data,
  input  uart_pkg::parity_t    parity_mode,
  output logic                 txd,
  output logic                 tx_busy,
  output logic                 clr_tx_cnt
);

  import uart_pkg::*;

  localparam int TW = $clog2(OVERSAMPLE);
  localparam int BW = $clog2(DATA_BITS);
  localparam logic [TW-1:0] TICK_LAST = TW'(OVERSAMPLE - 1);
  localparam logic [BW-1:0] BIT_LAST  = BW'(DATA_BITS - 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_PARITY,
    S_STOP
  } tx_state_t;

  tx_state_t            state;
  logic [TW-1:0]        tick_cnt;
  logic [BW-1:0]        bit_cnt;
  logic                 par_en;
  logic                 par_bit;
  logic [DATA_BITS-1:0] shreg;
  logic                 accept;
  logic                 bit_end;

  assign accept     = tx_start && (state == S_IDLE); // Starts while busy are dropped
  assign clr_tx_cnt = accept;
  assign bit_end    = tx_clk_en && (tick_cnt == TICK_LAST);
  assign tx_busy    = (state != S_IDLE);

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      state    <= S_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      par_en   <= 1'b0;
    end
    else if (accept)
    begin
      state    <= S_START;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      par_en   <= (parity_mode != PAR_NONE);
    end
    else if (tx_busy && tx_clk_en)
    begin
      if (bit_end)
      begin
        tick_cnt <= '0;
        case (state)
          S_START:  state <= S_DATA;
          S_DATA:
            if (bit_cnt == BIT_LAST)
              state <= par_en ? S_PARITY : S_STOP;
            else
              bit_cnt <= bit_cnt + 1'b1;
          S_PARITY: state <= S_STOP;
          default:  state <= S_IDLE; // End of stop bit
        endcase
      end
      else
        tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // Frame payload, parity fixed at acceptance
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      shreg   <= tx_data;
      par_bit <= (^tx_data) ^ (parity_mode == PAR_ODD);
    end
    else if (bit_end && state == S_DATA)
      shreg <= {1'b0, shreg[DATA_BITS-1:1]}; // LSB first
  end

  always_comb
  begin
    case (state)
      S_START:  txd = 1'b0;
      S_DATA:   txd = shreg[0];
      S_PARITY: txd = par_bit;
      default:  txd = 1'b1; // Idle and stop
    endcase
  end

  line_idle_high: assert property (@(posedge clk) disable iff (!nrst)
    !tx_busy |-> txd);

endmodule

`default_nettype wire

// File: uart_rx.sv
`default_nettype none

module uart_rx #(
  parameter int DATA_BITS  = 8,
  parameter int OVERSAMPLE = 16
) (
  input  logic                 clk,
  input  logic                 nrst,
  input  logic                 rx_clk_en,
  input  logic                 rxd,
  input  uart_pkg::parity_t    parity_mode,
  output logic [DATA_BITS-1:0] rx_data,
  output logic                 rx_valid,
  output logic                 rx_parity_err,
  output logic                 rx_frame_err
);

  import uart_pkg::*;

  localparam int TW = $clog2(OVERSAMPLE);
  localparam int BW = $clog2(DATA_BITS);
  localparam logic [TW-1:0] TICK_LAST = TW'(OVERSAMPLE - 1);
  localparam logic [TW-1:0] HALF_LAST = TW'(OVERSAMPLE / 2 - 1);
  localparam logic [BW-1:0] BIT_LAST  = BW'(DATA_BITS - 1);

  typedef enum logic [2:0] {
    R_IDLE,
    R_START,
    R_DATA,
    R_PARITY,
    R_STOP
  } rx_state_t;

  rx_state_t            state;
  logic                 rxd_meta;
  logic                 rxd_sync;
  logic [TW-1:0]        tick_cnt;
  logic [BW-1:0]        bit_cnt;
  logic                 par_err_q;
  logic [DATA_BITS-1:0] shreg;
  logic                 sample;

  assign sample = (tick_cnt == TICK_LAST); // Middle of current bit

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end
    else
    begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      state         <= R_IDLE;
      tick_cnt      <= '0;
      bit_cnt       <= '0;
      par_err_q     <= 1'b0;
      rx_valid      <= 1'b0;
      rx_parity_err <= 1'b0;
      rx_frame_err  <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      if (rx_clk_en)
      begin
        tick_cnt <= tick_cnt + 1'b1;
        case (state)
          R_IDLE:
          begin
            tick_cnt <= '0;
            if (!rxd_sync)
              state <= R_START;
          end
          R_START:
            if (tick_cnt == HALF_LAST)
            begin
              tick_cnt  <= '0;
              bit_cnt   <= '0;
              par_err_q <= 1'b0;
              state     <= rxd_sync ? R_IDLE : R_DATA; // Line back high, false start
            end
          R_DATA:
            if (sample)
            begin
              if (bit_cnt == BIT_LAST)
                state <= (parity_mode != PAR_NONE) ? R_PARITY : R_STOP;
              else
                bit_cnt <= bit_cnt + 1'b1;
            end
          R_PARITY:
            if (sample)
            begin
              par_err_q <= (^{rxd_sync, shreg}) ^ (parity_mode == PAR_ODD);
              state     <= R_STOP;
            end
          default:
            if (sample)
            begin
              rx_valid      <= 1'b1;
              rx_parity_err <= par_err_q;
              rx_frame_err  <= !rxd_sync; // Stop bit must be high
              state         <= R_IDLE;
            end
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_clk_en && sample)
    begin
      if (state == R_DATA)
        shreg <= {rxd_sync, shreg[DATA_BITS-1:1]};
      if (state == R_STOP)
        rx_data <= shreg;
    end
  end

  valid_single_cycle: assert property (@(posedge clk) disable iff (!nrst)
    rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// File: uart_core.sv
`default_nettype none

module uart_core #(
  parameter int DATA_BITS  = 8,
  parameter int OVERSAMPLE = 16
) (
  input  logic                 clk,
  input  logic                 nrst,
  input  uart_pkg::baud_div_t  bsel,
  input  logic                 change_cfg,
  input  logic                 rxen,
  input  logic                 txen,
  input  uart_pkg::parity_t    parity_mode,
  input  logic [DATA_BITS-1:0] tx_data,
  input  logic                 tx_start,
  output logic                 txd,
  output logic                 tx_busy,
  input  logic                 rxd,
  output logic [DATA_BITS-1:0] rx_data,
  output logic                 rx_valid,
  output logic                 rx_parity_err,
  output logic                 rx_frame_err
);

  logic rx_clk_en;
  logic tx_clk_en;
  logic clr_tx_cnt; // Transmit counter restart at frame start

  clk_gen_logic i_clk_gen_logic (
    .clk        (clk),
    .nrst       (nrst),
    .bsel       (bsel),
    .change_cfg (change_cfg),
    .rxen       (rxen),
    .txen       (txen),
    .clr_tx_cnt (clr_tx_cnt),
    .rx_clk_en  (rx_clk_en),
    .tx_clk_en  (tx_clk_en)
  );

  uart_tx #(
    .DATA_BITS  (DATA_BITS),
    .OVERSAMPLE (OVERSAMPLE)
  ) i_uart_tx (
    .clk         (clk),
    .nrst        (nrst),
    .tx_clk_en   (tx_clk_en),
    .tx_start    (tx_start),
    .tx_data     (tx_data),
    .parity_mode (parity_mode),
    .txd         (txd),
    .tx_busy     (tx_busy),
    .clr_tx_cnt  (clr_tx_cnt)
  );

  uart_rx #(
    .DATA_BITS  (DATA_BITS),
    .OVERSAMPLE (OVERSAMPLE)
  ) i_uart_rx (
    .clk           (clk),
    .nrst          (nrst),
    .rx_clk_en     (rx_clk_en),
    .rxd           (rxd),
    .parity_mode   (parity_mode),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

endmodule

`default_nettype wire

// File: tb_uart_core.sv
`default_nettype none

module tb_uart_core;

  import uart_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DRV_DLY    = 5;
  localparam int DATA_BITS  = 8;
  localparam int OVERSAMPLE = 16;
  // Bit periods of all tests at 64 cycles per bit for bsel 3 and 32 for bsel 1
  localparam int TEST_CYCLES = (100 + 66 + 13 + 12 + 10) * 64 + (10 + 20) * 32;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

  logic                 clk;
  logic                 nrst;
  baud_div_t            bsel;
  logic                 change_cfg;
  logic                 rxen;
  logic                 txen;
  parity_t              parity_mode;
  logic [DATA_BITS-1:0] tx_data;
  logic                 tx_start;
  logic                 txd;
  logic                 tx_busy;
  logic                 rxd;
  logic [DATA_BITS-1:0] rx_data;
  logic                 rx_valid;
  logic                 rx_parity_err;
  logic                 rx_frame_err;
  logic                 loopback;
  logic                 rxd_drv;
  logic [DATA_BITS-1:0] got_data;
  logic                 got_perr;
  logic                 got_ferr;
  integer               seed;
  int                   error_cnt = 0;
  int                   valid_cnt = 0;
  int                   cycle_cnt = 0;

  assign rxd = loopback ? txd : rxd_drv; // Loopback or driven line

  uart_core #(
    .DATA_BITS  (DATA_BITS),
    .OVERSAMPLE (OVERSAMPLE)
  ) i_uart_core (
    .clk           (clk),
    .nrst          (nrst),
    .bsel          (bsel),
    .change_cfg    (change_cfg),
    .rxen          (rxen),
    .txen          (txen),
    .parity_mode   (parity_mode),
    .tx_data       (tx_data),
    .tx_start      (tx_start),
    .txd           (txd),
    .tx_busy       (tx_busy),
    .rxd           (rxd),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Received frame capture
  always @(posedge clk)
  begin
    if (rx_valid)
    begin
      valid_cnt <= valid_cnt + 1;
      got_data  <= rx_data;
      got_perr  <= rx_parity_err;
      got_ferr  <= rx_frame_err;
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT)
    begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      error_cnt++;
      finish_run();
    end
  end

  task automatic finish_run;
    $display("Frames received: %0d, errors: %0d", valid_cnt, error_cnt);
    if (error_cnt == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    error_cnt++;
    $display("** Error: %s expected %0h actual %0h", test, exp, act);
  endtask

  function automatic int bit_period;
    return OVERSAMPLE * (int'(bsel) + 1);
  endfunction

  // Parity bit that completes an even or odd count of ones
  function automatic logic parity_of(input logic [7:0] data, input parity_t mode);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < DATA_BITS; i++)
      ones += data[i];
    if (mode == PAR_ODD)
      return (ones % 2) == 0;
    return (ones % 2) == 1;
  endfunction

  task automatic step;
    @(posedge clk);
    #DRV_DLY;
  endtask

  task automatic send_byte(input logic [7:0] data);
    step();
    tx_data  = data;
    tx_start = 1'b1;
    step();
    tx_start = 1'b0;
  endtask

  task automatic loop_check(input string test, input logic [7:0] data);
    int n;
    n = valid_cnt;
    send_byte(data);
    while (valid_cnt == n)
      @(negedge clk);
    if (got_data !== data)
      report_mismatch(test, data, got_data);
    if ({got_perr, got_ferr} !== 2'b00)
      report_mismatch(test, 2'b00, {got_perr, got_ferr});
    while (tx_busy)
      @(negedge clk);
  endtask

  // Start bit, data LSB first, optional parity, stop, then two idle bits
  task automatic drive_frame(input logic [7:0] data, input logic with_par,
                             input logic par, input logic stop);
    logic [10:0] bits;
    int          nbits;
    int          i;
    bits  = with_par ? {stop, par, data, 1'b0} : {1'b1, stop, data, 1'b0};
    nbits = with_par ? 11 : 10;
    step();
    for (i = 0; i < nbits; i++)
    begin
      rxd_drv = bits[i];
      repeat (bit_period()) step();
    end
    rxd_drv = 1'b1;
    repeat (2 * bit_period()) step();
  endtask

  task automatic test_reset;
    if (txd !== 1'b1)
      report_mismatch("reset txd", 1'b1, txd);
    if ({tx_busy, rx_valid, rx_parity_err, rx_frame_err} !== 4'b0000)
      report_mismatch("reset flags", 4'b0000, {tx_busy, rx_valid, rx_parity_err, rx_frame_err});
  endtask

  task automatic test_loopback;
    int i;
    for (i = 0; i < 10; i++)
      loop_check("loopback", 8'($random(seed)));
  endtask

  task automatic test_parity;
    logic [7:0] data;
    int         n;
    int         i;
    step();
    parity_mode = PAR_EVEN;
    for (i = 0; i < 3; i++)
      loop_check("parity even", 8'($random(seed)));
    step();
    parity_mode = PAR_ODD;
    for (i = 0; i < 3; i++)
      loop_check("parity odd", 8'($random(seed)));
    data     = 8'($random(seed));
    n        = valid_cnt;
    loopback = 1'b0;
    drive_frame(data, 1'b1, !parity_of(data, PAR_ODD), 1'b1);
    if (valid_cnt != n + 1)
      report_mismatch("parity bad frames", n + 1, valid_cnt);
    if (got_perr !== 1'b1)
      report_mismatch("parity bad flag", 1'b1, got_perr);
    if (got_data !== data)
      report_mismatch("parity bad data", data, got_data);
    parity_mode = PAR_NONE;
    loopback    = 1'b1;
  endtask

  task automatic test_framing;
    logic [7:0] data;
    int         n;
    data     = 8'($random(seed));
    n        = valid_cnt;
    loopback = 1'b0;
    drive_frame(data, 1'b0, 1'b0, 1'b0);
    if (valid_cnt != n + 1)
      report_mismatch("framing frames", n + 1, valid_cnt);
    if (got_ferr !== 1'b1)
      report_mismatch("framing flag", 1'b1, got_ferr);
    // Glitch of an eighth of a bit
    n       = valid_cnt;
    rxd_drv = 1'b0;
    repeat (bit_period() / 8) step();
    rxd_drv = 1'b1;
    repeat (10 * bit_period()) step();
    if (valid_cnt != n)
      report_mismatch("false start", n, valid_cnt);
    loopback = 1'b1;
  endtask

  task automatic test_timing;
    int start_len;
    int busy_len;
    int n;
    step();
    bsel       = 12'd1;
    change_cfg = 1'b1;
    step();
    change_cfg = 1'b0;
    start_len  = 0;
    busy_len   = 0;
    n          = valid_cnt;
    send_byte(8'hFF); // Only the start bit is low
    @(negedge clk);
    while (tx_busy)
    begin
      if (!txd)
        start_len++;
      busy_len++;
      @(negedge clk);
    end
    if (start_len != OVERSAMPLE * 2)
      report_mismatch("start bit length", OVERSAMPLE * 2, start_len);
    if (busy_len != (2 + DATA_BITS) * OVERSAMPLE * 2)
      report_mismatch("busy length", (2 + DATA_BITS) * OVERSAMPLE * 2, busy_len);
    if (valid_cnt != n + 1)
      report_mismatch("timing frames", n + 1, valid_cnt);
    if (got_data !== 8'hFF)
      report_mismatch("timing data", 8'hFF, got_data);
  endtask

  task automatic test_backpressure;
    logic [7:0] first;
    int         n;
    first = 8'($random(seed));
    n     = valid_cnt;
    send_byte(first);
    repeat (5) step();
    send_byte(~first);
    while (tx_busy)
      @(negedge clk);
    repeat (10 * bit_period()) @(negedge clk);
    if (valid_cnt != n + 1)
      report_mismatch("back-pressure frames", n + 1, valid_cnt);
    if (got_data !== first)
      report_mismatch("back-pressure data", first, got_data);
  endtask

  initial
  begin
    seed        = 32'h08f3_41b2;
    nrst        = 1'b0;
    bsel        = 12'd3;
    change_cfg  = 1'b0;
    rxen        = 1'b1;
    txen        = 1'b1;
    parity_mode = PAR_NONE;
    tx_data     = '0;
    tx_start    = 1'b0;
    loopback    = 1'b1;
    rxd_drv     = 1'b1;
    repeat (3) @(posedge clk);
    #DRV_DLY;
    nrst = 1'b1;
    step();
    test_reset();
    test_loopback();
    test_parity();
    test_framing();
    test_timing();
    test_backpressure();
    finish_run();
  end

endmodule

`default_nettype wire

// File: list.f
uart_pkg.sv
clk_gen_logic.sv
uart_tx.sv
uart_rx.sv
uart_core.sv
tb_uart_core.sv
